// ==== mcu_ao_ctrl_testdata.txt ====
// kind cycles ackdly stim{dbg_n,sleep,cfg} irq_src gpio clr exp_pwr{cpu,per,b1,b0} exp_irq exp_rst
// kind 0 waits the cycles, kind 1 waits for a match up to them; ackdly ff is random
0 4 0 80 000 00 00 FFFFF 00000000 7
0 1 0 80 100 00 00 FFFFF 00000008 7
0 1 0 80 080 00 00 FFFFF 00000800 7
0 1 0 80 008 00 00 FFFFF 00000080 7
0 1 0 80 010 00 00 FFFFF 00010000 7
0 1 0 80 020 00 00 FFFFF 00020000 7
0 1 0 80 040 00 00 FFFFF 00040000 7
0 1 0 80 004 00 00 FFFFF 00080000 7
0 1 0 80 002 00 00 FFFFF 00100000 7
0 1 0 80 001 00 00 FFFFF 00200000 7
0 3 0 80 000 01 00 FFFFF 00000000 7
0 1 0 80 000 01 00 FFFFF 00400000 7
0 3 0 80 000 00 00 FFFFF 00400000 7
0 1 0 80 000 00 01 FFFFF 00400000 7
0 1 0 80 000 00 00 FFFFF 00000000 7
0 1 0 90 000 00 00 FF7FF 00000000 7
0 1 0 90 000 00 00 FD7FF 00000000 7
0 1 0 90 000 00 00 FC7FF 00000000 5
0 1 3 90 000 00 00 F87FF 00000000 5
0 5 0 90 000 00 00 F87FF 00000000 5
0 1 ff 80 000 00 00 FC7FF 00000000 5
1 14 0 80 000 00 00 FE7FF 00000000 5
0 1 0 80 000 00 00 FF7FF 00000000 7
0 1 0 80 000 00 00 FFFFF 00000000 7
0 1 0 81 000 00 00 FFFFC 00000000 7
0 1 0 80 000 00 00 FFFFF 00000000 7
0 1 0 88 000 00 00 FFFBF 00000000 7
0 1 0 88 000 00 00 FFEBF 00000000 7
0 1 0 88 000 00 00 FFE3F 00000000 7
0 1 2 88 000 00 00 FFC3F 00000000 7
0 5 0 88 000 00 00 FFC3F 00000000 7
0 1 ff 80 000 00 00 FFE3F 00000000 7
1 14 0 80 000 00 00 FFF3F 00000000 7
0 1 0 80 000 00 00 FFFBF 00000000 7
0 1 0 80 000 00 00 FFFFF 00000000 7
1 1e 2 e0 000 00 00 0FFFF 00000000 3
0 6 0 e0 000 00 00 0FFFF 00000000 3
1 1e ff e0 100 00 00 FFFFF 00000008 7
0 3 0 80 000 00 00 FFFFF 00000000 7
0 1 0 00 000 00 00 FFFFF 00000000 0
0 1 0 80 000 00 00 FFFFF 00000000 7

// ==== mcu_ao_ctrl.f ====
mcu_pkg.sv
power_domain_fsm.sv
power_manager.sv
irq_router.sv
reset_ctrl.sv
mcu_ao_ctrl.sv
tb_clkgen.sv
tb_mcu_ao_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f mcu_ao_ctrl.f --top-module tb_mcu_ao_ctrl -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }
grep -q '^>>> PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb_mcu_ao_ctrl.sv ====
/*
  Testbench for the always-on controller. Steps come from the testdata file,
  a responder answers the power switches, outputs are checked per step.
*/
`timescale 1ns/1ps

module tb_mcu_ao_ctrl;

  localparam int COLS = 10;
  localparam int MAX_STEPS = 64;

  logic                                          clk;
  logic                                          rst_n;
  logic                                          debug_n;
  logic                                          core_sleep;
  mcu_pkg::pwr_cfg_t                             pwr_cfg;
  mcu_pkg::irq_src_t                             irq_src;
  logic [mcu_pkg::NUM_GPIO_AO-1:0]               gpio;
  logic [mcu_pkg::NUM_GPIO_AO-1:0]               gpio_clr;
  mcu_pkg::pwr_ctrl_out_t                        cpu_pwr;
  mcu_pkg::pwr_ctrl_out_t                        periph_pwr;
  mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr;
  logic [3:0]                                    ack_n = '1;
  logic [3:0]                                    en_n;
  logic [mcu_pkg::IRQ_W-1:0]                     irq;
  logic                                          cpu_rst_n;
  logic                                          periph_rst_n;
  logic                                          ext_dbg_rst_n;

  logic [31:0] stim_mem [0:MAX_STEPS*COLS-1];
  logic [15:0] lfsr_q;
  int          num_steps;
  int          longest;
  int          limit_cycles;
  int          cur_step;
  int          cur_delay;
  int          value_errs;
  int          other_errs;
  int          wait_cnt [4];
  int          ack_dly [4];

  tb_clkgen clkgen_i (
    .clk_o  (clk),
    .rst_n_o(rst_n)
  );

  mcu_ao_ctrl uut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .debug_ndmreset_n_i(debug_n),
    .core_sleep_i      (core_sleep),
    .pwr_cfg_i         (pwr_cfg),
    .irq_src_i         (irq_src),
    .gpio_ao_i         (gpio),
    .gpio_irq_clr_i    (gpio_clr),
    .cpu_pwr_o         (cpu_pwr),
    .periph_pwr_o      (periph_pwr),
    .bank_pwr_o        (bank_pwr),
    .cpu_ack_i         (ack_n[3]),
    .periph_ack_i      (ack_n[2]),
    .bank_ack_i        (ack_n[1:0]),
    .irq_o             (irq),
    .cpu_rst_no        (cpu_rst_n),
    .periph_rst_no     (periph_rst_n),
    .ext_debug_rst_no  (ext_dbg_rst_n)
  );

  assign en_n = {cpu_pwr.pwrgate_en_n, periph_pwr.pwrgate_en_n,
                 bank_pwr[1].pwrgate_en_n, bank_pwr[0].pwrgate_en_n};

  // switch responder, delay latched when a domain's switch first changes
  always @(negedge clk) begin
    for (int d = 0; d < 4; d++) begin
      if (ack_n[d] == en_n[d]) begin
        wait_cnt[d] = 0;
      end else begin
        if (wait_cnt[d] == 0) ack_dly[d] = cur_delay;
        if (wait_cnt[d] >= ack_dly[d]) ack_n[d] <= en_n[d];
        wait_cnt[d] = wait_cnt[d] + 1;
      end
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = v * 2 + (lfsr_q[0] ? 1 : 0);
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic outputs_match(input int base);
    return ({cpu_pwr, periph_pwr, bank_pwr} === stim_mem[base+7][19:0]) &&
           (irq === stim_mem[base+8]) &&
           ({cpu_rst_n, periph_rst_n, ext_dbg_rst_n} === stim_mem[base+9][2:0]);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("FAIL step %0d %s: got %h, expected %h", cur_step, name, got, exp);
  endtask

  task automatic run_step(input int s);
    int base;
    int n;
    base = s * COLS;
    cur_step = s;
    {debug_n, core_sleep, pwr_cfg} = stim_mem[base+3][7:0];
    irq_src = stim_mem[base+4][8:0];
    gpio = stim_mem[base+5][7:0];
    gpio_clr = stim_mem[base+6][7:0];
    if (stim_mem[base+2] == 32'hFF) cur_delay <= random_bits(3);
    else cur_delay <= stim_mem[base+2];
    // clear is a one-cycle pulse
    @(negedge clk);
    gpio_clr = '0;
    n = 1;
    if (stim_mem[base] == 0) begin
      repeat (stim_mem[base+1] - 1) @(negedge clk);
    end else begin
      while (!outputs_match(base) && n < stim_mem[base+1]) begin
        @(negedge clk);
        n++;
      end
      if (!outputs_match(base)) begin
        other_errs++;
        $display("step %0d: outputs did not settle within %0d cycles", s, n);
      end
    end
    if (cpu_pwr !== stim_mem[base+7][19:15])
      report_mismatch("cpu_pwr_o", {27'b0, cpu_pwr}, {27'b0, stim_mem[base+7][19:15]});
    if (periph_pwr !== stim_mem[base+7][14:10])
      report_mismatch("periph_pwr_o", {27'b0, periph_pwr}, {27'b0, stim_mem[base+7][14:10]});
    if (bank_pwr !== stim_mem[base+7][9:0])
      report_mismatch("bank_pwr_o", {22'b0, bank_pwr}, {22'b0, stim_mem[base+7][9:0]});
    if (irq !== stim_mem[base+8])
      report_mismatch("irq_o", irq, stim_mem[base+8]);
    if (cpu_rst_n !== stim_mem[base+9][2])
      report_mismatch("cpu_rst_no", {31'b0, cpu_rst_n}, {31'b0, stim_mem[base+9][2]});
    if (periph_rst_n !== stim_mem[base+9][1])
      report_mismatch("periph_rst_no", {31'b0, periph_rst_n}, {31'b0, stim_mem[base+9][1]});
    if (ext_dbg_rst_n !== stim_mem[base+9][0])
      report_mismatch("ext_debug_rst_no", {31'b0, ext_dbg_rst_n}, {31'b0, stim_mem[base+9][0]});
  endtask

  initial begin
    debug_n = 1'b1;
    core_sleep = 1'b0;
    pwr_cfg = '0;
    irq_src = '0;
    gpio = '0;
    gpio_clr = '0;
    cur_delay = 0;
    lfsr_q = 16'd39840;
    for (int i = 0; i < MAX_STEPS * COLS; i++) stim_mem[i] = '1;
    $readmemh("mcu_ao_ctrl_testdata.txt", stim_mem);
    // an all-ones kind word marks the end of the data
    while (num_steps < MAX_STEPS && stim_mem[num_steps*COLS] != 32'hFFFF_FFFF) begin
      if (stim_mem[num_steps*COLS+1] > longest) longest = stim_mem[num_steps*COLS+1];
      num_steps++;
    end
    if (num_steps == 0) begin
      other_errs++;
      $display("no test steps could be read from the data file");
    end
    limit_cycles = num_steps * longest + 50;
    wait (rst_n);
    repeat (4) @(negedge clk);
    for (int s = 0; s < num_steps; s++) run_step(s);
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== tb_clkgen.sv ====
/*
  Testbench clock and reset source: 100 ns clock, reset held for 10 cycles.
*/
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam time HALF_PERIOD = 50ns;

  initial clk_o = 1'b0;
  always #(HALF_PERIOD) clk_o = ~clk_o;

  // release on a falling edge, away from the DUT's sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== mcu_ao_ctrl.sv ====
/*
  Always-on control slice of the microcontroller: resets, interrupt vector
  and power sequencing. Connects the controller blocks only.
*/
`timescale 1ns/1ps

module mcu_ao_ctrl (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           debug_ndmreset_n_i,
  input  logic                                           core_sleep_i,
  input  mcu_pkg::pwr_cfg_t                              pwr_cfg_i,
  input  mcu_pkg::irq_src_t                              irq_src_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0]                gpio_ao_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0]                gpio_irq_clr_i,
  output mcu_pkg::pwr_ctrl_out_t                         cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                         periph_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_o,
  input  mcu_pkg::pwr_ctrl_in_t                          cpu_ack_i,
  input  mcu_pkg::pwr_ctrl_in_t                          periph_ack_i,
  input  mcu_pkg::pwr_ctrl_in_t  [mcu_pkg::NUM_BANKS-1:0] bank_ack_i,
  output logic [mcu_pkg::IRQ_W-1:0]                      irq_o,
  output logic                                           cpu_rst_no,
  output logic                                           periph_rst_no,
  output logic                                           ext_debug_rst_no
);

  logic ao_rst_n;

  reset_ctrl rst_i (
    .clk_i,
    .rst_n_i,
    .debug_ndmreset_n_i,
    .cpu_dom_rst_n_i   (cpu_pwr_o.rst_n),
    .periph_dom_rst_n_i(periph_pwr_o.rst_n),
    .ao_rst_no         (ao_rst_n),
    .cpu_rst_no,
    .periph_rst_no,
    .ext_debug_rst_no
  );

  irq_router irq_i (
    .clk_i,
    .rst_n_i(ao_rst_n),
    .irq_src_i,
    .gpio_ao_i,
    .gpio_irq_clr_i,
    .irq_o
  );

  // the registered vector doubles as the wake-up source
  power_manager pwr_i (
    .clk_i,
    .rst_n_i      (ao_rst_n),
    .cfg_i        (pwr_cfg_i),
    .core_sleep_i,
    .irq_pending_i(irq_o),
    .cpu_ack_i,
    .periph_ack_i,
    .bank_ack_i,
    .cpu_pwr_o,
    .periph_pwr_o,
    .bank_pwr_o
  );

endmodule

// ==== reset_ctrl.sv ====
/*
  Synchronizes the external reset and merges it with the debug-module reset
  and the per-domain resets from the power manager.
*/
`timescale 1ns/1ps

module reset_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic debug_ndmreset_n_i,
  input  logic cpu_dom_rst_n_i,
  input  logic periph_dom_rst_n_i,
  output logic ao_rst_no,
  output logic cpu_rst_no,
  output logic periph_rst_no,
  output logic ext_debug_rst_no
);

  logic [mcu_pkg::RST_SYNC_STAGES-1:0] rst_sync_q;

  // asserts asynchronously, releases after the chain fills
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[mcu_pkg::RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign ao_rst_no        = rst_sync_q[mcu_pkg::RST_SYNC_STAGES-1];
  assign ext_debug_rst_no = ao_rst_no & debug_ndmreset_n_i;
  assign cpu_rst_no       = ext_debug_rst_no & cpu_dom_rst_n_i;
  assign periph_rst_no    = ext_debug_rst_no & periph_dom_rst_n_i;

endmodule

// ==== irq_router.sv ====
/*
  Builds the registered core interrupt vector, fast field included.
  Always-on GPIO rising edges set sticky pending bits until cleared.
*/
`timescale 1ns/1ps

module irq_router (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  mcu_pkg::irq_src_t               irq_src_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_ao_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_irq_clr_i,
  output logic [mcu_pkg::IRQ_W-1:0]       irq_o
);

  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_meta_q;
  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_sync_q;
  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_prev_q;
  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_rise;
  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_pend_q;
  logic [mcu_pkg::IRQ_W-1:0]       irq_vec;

  assign gpio_rise = gpio_sync_q & ~gpio_prev_q;

  // two-flop synchronizer, then edge detect
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      gpio_prev_q <= '0;
    end else begin
      gpio_meta_q <= gpio_ao_i;
      gpio_sync_q <= gpio_meta_q;
      gpio_prev_q <= gpio_sync_q;
    end
  end

  // set beats clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_pend_q <= '0;
    end else begin
      gpio_pend_q <= (gpio_pend_q & ~gpio_irq_clr_i) | gpio_rise;
    end
  end

  always_comb begin
    irq_vec = '0;
    irq_vec[mcu_pkg::IRQ_SOFTWARE_BIT] = irq_src_i.software;
    irq_vec[mcu_pkg::IRQ_TIMER0_BIT]   = irq_src_i.timer[0];
    irq_vec[mcu_pkg::IRQ_EXTERNAL_BIT] = irq_src_i.external;
    irq_vec[mcu_pkg::IRQ_FAST_BASE +: 3] = irq_src_i.timer[3:1];
    irq_vec[mcu_pkg::IRQ_FAST_BASE + 3]  = irq_src_i.dma_done;
    irq_vec[mcu_pkg::IRQ_FAST_BASE + 4]  = irq_src_i.spi;
    irq_vec[mcu_pkg::IRQ_FAST_BASE + 5]  = irq_src_i.spi_flash;
    irq_vec[mcu_pkg::IRQ_FAST_BASE + 6 +: mcu_pkg::NUM_GPIO_AO] = gpio_pend_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= irq_vec;
    end
  end

  // unmapped vector positions never fire
  a_reserved_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (irq_o[mcu_pkg::IRQ_SOFTWARE_BIT-1:0] == '0) &&
    (irq_o[mcu_pkg::IRQ_TIMER0_BIT-1:mcu_pkg::IRQ_SOFTWARE_BIT+1] == '0) &&
    (irq_o[mcu_pkg::IRQ_EXTERNAL_BIT-1:mcu_pkg::IRQ_TIMER0_BIT+1] == '0) &&
    (irq_o[mcu_pkg::IRQ_FAST_BASE-1:mcu_pkg::IRQ_EXTERNAL_BIT+1] == '0) &&
    (irq_o[mcu_pkg::IRQ_W-1:mcu_pkg::IRQ_FAST_BASE+6+mcu_pkg::NUM_GPIO_AO] == '0));

endmodule

// ==== power_manager.sv ====
/*
  Power manager: one sequencer per CPU, peripheral and memory bank domain.
  Puts the CPU domain to sleep on request and wakes it on any interrupt.
*/
`timescale 1ns/1ps

module power_manager (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  mcu_pkg::pwr_cfg_t                              cfg_i,
  input  logic                                           core_sleep_i,
  input  logic [mcu_pkg::IRQ_W-1:0]                      irq_pending_i,
  input  mcu_pkg::pwr_ctrl_in_t                          cpu_ack_i,
  input  mcu_pkg::pwr_ctrl_in_t                          periph_ack_i,
  input  mcu_pkg::pwr_ctrl_in_t  [mcu_pkg::NUM_BANKS-1:0] bank_ack_i,
  output mcu_pkg::pwr_ctrl_out_t                         cpu_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t                         periph_pwr_o,
  output mcu_pkg::pwr_ctrl_out_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_o
);

  logic cpu_sleep_q;
  logic irq_any;

  assign irq_any = |irq_pending_i;

  // wake has priority over a new sleep request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cpu_sleep_q <= 1'b0;
    end else if (irq_any) begin
      cpu_sleep_q <= 1'b0;
    end else if (cfg_i.cpu_sleep_en && core_sleep_i) begin
      cpu_sleep_q <= 1'b1;
    end
  end

  power_domain_fsm #(
    .HAS_RETENTION(1'b0)
  ) cpu_domain_i (
    .clk_i,
    .rst_n_i,
    .down_req_i(cpu_sleep_q),
    .ret_req_i (1'b0),
    .pwr_i     (cpu_ack_i),
    .pwr_o     (cpu_pwr_o)
  );

  power_domain_fsm #(
    .HAS_RETENTION(1'b0)
  ) periph_domain_i (
    .clk_i,
    .rst_n_i,
    .down_req_i(cfg_i.periph_off),
    .ret_req_i (1'b0),
    .pwr_i     (periph_ack_i),
    .pwr_o     (periph_pwr_o)
  );

  for (genvar i = 0; i < mcu_pkg::NUM_BANKS; i++) begin : g_bank
    power_domain_fsm #(
      .HAS_RETENTION(1'b1)
    ) bank_domain_i (
      .clk_i,
      .rst_n_i,
      .down_req_i(cfg_i.bank_off[i]),
      .ret_req_i (cfg_i.bank_ret[i]),
      .pwr_i     (bank_ack_i[i]),
      .pwr_o     (bank_pwr_o[i])
    );
  end

endmodule

// ==== power_domain_fsm.sv ====
/*
  Sequencer for one power domain: clock gate, isolation, reset and switch,
  with an optional retention mode for memory banks.
*/
`timescale 1ns/1ps

module power_domain_fsm #(
  parameter bit HAS_RETENTION = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   down_req_i,
  input  logic                   ret_req_i,
  input  mcu_pkg::pwr_ctrl_in_t  pwr_i,
  output mcu_pkg::pwr_ctrl_out_t pwr_o
);

  mcu_pkg::pwr_state_e state_q;
  mcu_pkg::pwr_state_e state_d;
  logic                ret_en;

  assign ret_en = HAS_RETENTION && ret_req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mcu_pkg::ON;
    end else begin
      state_q <= state_d;
    end
  end

  // down request wins over retention in ON
  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_pkg::ON: begin
        if (down_req_i) begin
          state_d = mcu_pkg::CLK_OFF;
        end else if (ret_en) begin
          state_d = mcu_pkg::RET;
        end
      end
      mcu_pkg::CLK_OFF: state_d = mcu_pkg::ISO_ON;
      mcu_pkg::ISO_ON: state_d = mcu_pkg::RST_ON;
      mcu_pkg::RST_ON: state_d = mcu_pkg::SWITCH_OFF;
      mcu_pkg::SWITCH_OFF: begin
        if (!pwr_i.pwrgate_ack_n) state_d = mcu_pkg::OFF;
      end
      mcu_pkg::OFF: begin
        if (!down_req_i) state_d = mcu_pkg::SWITCH_ON;
      end
      mcu_pkg::SWITCH_ON: begin
        if (pwr_i.pwrgate_ack_n) state_d = mcu_pkg::ISO_OFF;
      end
      mcu_pkg::ISO_OFF: state_d = mcu_pkg::RST_OFF;
      mcu_pkg::RST_OFF: state_d = mcu_pkg::ON;
      mcu_pkg::RET: begin
        if (!ret_en) state_d = mcu_pkg::ON;
      end
      default: state_d = mcu_pkg::ON;
    endcase
  end

  // moore decode, controls released in reverse order on the way up
  always_comb begin
    pwr_o = '1;
    case (state_q)
      mcu_pkg::CLK_OFF: begin
        pwr_o.clkgate_en_n = 1'b0;
      end
      mcu_pkg::ISO_ON: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.isogate_en_n = 1'b0;
      end
      mcu_pkg::RST_ON, mcu_pkg::SWITCH_ON: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.isogate_en_n = 1'b0;
        pwr_o.rst_n        = 1'b0;
      end
      mcu_pkg::SWITCH_OFF, mcu_pkg::OFF: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.isogate_en_n = 1'b0;
        pwr_o.rst_n        = 1'b0;
        pwr_o.pwrgate_en_n = 1'b0;
      end
      mcu_pkg::ISO_OFF: begin
        pwr_o.clkgate_en_n = 1'b0;
        pwr_o.rst_n        = 1'b0;
      end
      mcu_pkg::RST_OFF: begin
        pwr_o.clkgate_en_n = 1'b0;
      end
      mcu_pkg::RET: begin
        pwr_o.clkgate_en_n   = 1'b0;
        pwr_o.retentive_en_n = 1'b0;
      end
      default: pwr_o = '1;
    endcase
  end

  // a switched-off domain must already be isolated and held in reset
  a_switch_iso_rst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pwr_o.pwrgate_en_n |-> (!pwr_o.isogate_en_n && !pwr_o.rst_n));

  if (!HAS_RETENTION) begin : g_no_ret
    a_no_retention: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pwr_o.retentive_en_n);
  end

endmodule

// ==== mcu_pkg.sv ====
/*
  Shared constants, state and struct types for the always-on controller.
  Other files refer to these by scoped names.
*/
package mcu_pkg;

  localparam int NUM_BANKS = 2;
  localparam int NUM_GPIO_AO = 8;
  localparam int IRQ_W = 32;

  // core interrupt vector layout
  localparam int IRQ_SOFTWARE_BIT = 3;
  localparam int IRQ_TIMER0_BIT = 7;
  localparam int IRQ_EXTERNAL_BIT = 11;
  localparam int IRQ_FAST_BASE = 16;

  localparam int RST_SYNC_STAGES = 2;

  // power domain sequencer states
  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SWITCH_OFF,
    OFF,
    SWITCH_ON,
    ISO_OFF,
    RST_OFF,
    RET
  } pwr_state_e;

  // all controls active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef struct packed {
    logic pwrgate_ack_n;
  } pwr_ctrl_in_t;

  typedef struct packed {
    logic                 cpu_sleep_en;
    logic                 periph_off;
    logic [NUM_BANKS-1:0] bank_off;
    logic [NUM_BANKS-1:0] bank_ret;
  } pwr_cfg_t;

  typedef struct packed {
    logic       software;
    logic       external;
    logic [3:0] timer;
    logic       dma_done;
    logic       spi;
    logic       spi_flash;
  } irq_src_t;

endpackage
